// ==== Makefile ====
# Verilator build and run of the rename block testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_rename_unit
FLIST     ?= rename_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== free_list.sv ====
`timescale 1ns/1ns
// Free list of physical tags
// Circular FIFO of PHYS_REGS-ARCH_REGS slots, full after reset
// Dispatch pops at the head, retirement pushes the old tag at the tail
// Flush rewinds the head over the tags still held by the ROB
module free_list
    import rename_cfg_pkg::*;
#(
    parameter int PHYS_REGS = 64
) (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                dispatch,
    input  logic                flush,
    input  logic                retire,
    input  phys_tag_t           retire_old_tag,
    input  logic [TAG_BITS:0]   rob_count,
    output phys_tag_t           new_tag,
    output logic                empty,
    output logic [TAG_BITS-1:0] count
);
    localparam int FREE  = PHYS_REGS - ARCH_REGS;
    localparam int PTR_W = $clog2(FREE);

    phys_tag_t        tags [FREE];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] head_rewind;

    // Wrap at FREE, which need not be a power of two
    function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FREE - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Head minus ROB occupancy, modulo FREE
    always_comb begin
        int back;
        back = int'(head) + FREE - int'(rob_count);
        if (back >= FREE) begin
            back = back - FREE;
        end
        head_rewind = PTR_W'(back);
    end

    assign new_tag = tags[head];
    assign empty   = (count == '0);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            // Tags above the architectural ones, in ascending order
            for (int i = 0; i < FREE; i++) begin
                tags[i] <= phys_tag_t'(ARCH_REGS + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= TAG_BITS'(FREE);
        end else if (flush) begin
            // In-flight tags come back in their original order
            head  <= head_rewind;
            count <= count + rob_count[TAG_BITS-1:0];
        end else begin
            if (dispatch) begin
                head <= bump(head);
            end
            if (retire) begin
                tags[tail] <= retire_old_tag;
                tail       <= bump(tail);
            end
            count <= count + TAG_BITS'(retire) - TAG_BITS'(dispatch);
        end
    end

endmodule

// ==== map_table.sv ====
`timescale 1ns/1ns
// Rename map table
// Speculative map serves dispatch lookups and takes each new tag,
// retirement map follows committed state only
// Flush copies the retirement map back over the speculative one
module map_table
    import rename_cfg_pkg::*;
#(
    parameter int PHYS_REGS = 64
) (
    input  logic      clock,
    input  logic      arst_n,
    input  logic      dispatch,
    input  logic      flush,
    input  arch_reg_t dst,
    input  arch_reg_t src1,
    input  arch_reg_t src2,
    input  phys_tag_t new_tag,
    input  logic      retire,
    input  arch_reg_t retire_arch,
    input  phys_tag_t retire_tag,
    output phys_tag_t old_tag,
    output phys_tag_t src1_tag,
    output phys_tag_t src2_tag
);
    // Entries only as wide as the physical file needs
    localparam int TAG_W = $clog2(PHYS_REGS);

    logic [TAG_W-1:0] spec_map [ARCH_REGS];
    logic [TAG_W-1:0] arch_map [ARCH_REGS];

    // Lookups see the map before this dispatch writes it,
    // so a source naming dst gets the previous producer
    assign old_tag  = phys_tag_t'(spec_map[dst]);
    assign src1_tag = phys_tag_t'(spec_map[src1]);
    assign src2_tag = phys_tag_t'(spec_map[src2]);

    //////////////////////////////////////////////////
    // Speculative map
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            // Identity mapping out of reset
            for (int i = 0; i < ARCH_REGS; i++) begin
                spec_map[i] <= TAG_W'(i);
            end
        end else if (flush) begin
            spec_map <= arch_map;
        end else if (dispatch) begin
            spec_map[dst] <= new_tag[TAG_W-1:0];
        end
    end

    //////////////////////////////////////////////////
    // Retirement map
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                arch_map[i] <= TAG_W'(i);
            end
        end else if (retire) begin
            arch_map[retire_arch] <= retire_tag[TAG_W-1:0];
        end
    end

endmodule

// ==== rename_cases.txt ====
// Columns: kind (0 write, 1 read), word address, write data or expected read data, expected err
// Dispatch word: dst | src1 << 5 | src2 << 10, the last line (kind ff) ends the list
1 5 00002000 0
0 0 00000823 0
1 3 01000320 0
1 4 00000002 0
0 0 00000c64 0
1 3 20010421 0
1 4 00000020 0
0 0 00000083 0
1 3 21022022 0
1 4 00000000 0
1 5 00001d03 0
// Out of order completion, then illegal completions
0 1 00000002 0
0 1 00000002 1
0 1 00000005 1
0 1 00000000 0
1 5 00001e02 0
0 1 00000001 0
1 5 00002000 0
// Wrong direction and unmapped word
1 0 00000000 1
0 3 00000000 1
1 6 00000000 1
// Flush with two entries in flight, one of them completed
0 0 00001065 0
1 3 22030523 0
0 0 000000a3 0
1 3 23042224 0
0 1 00000004 0
0 2 00000000 0
0 0 00001466 0
1 3 22000623 0
1 4 00000005 0
1 5 00001f01 0
0 1 00000000 0
1 5 00002000 0
ff 0 00000000 0

// ==== rename_cfg_pkg.sv ====
// Architectural sizes and tag types for the rename block
// Also holds the bus command word, which is read either as a
// dispatch or as a completion depending on the address written
// Imported by every RTL module that handles registers or tags
package rename_cfg_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    // Architectural register file
    localparam int ARCH_REGS = 32;

    // Width of tag and ROB index fields in bus words
    // Caps PHYS_REGS and ROB_DEPTH at 256
    localparam int TAG_BITS = 8;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    typedef logic [4:0] arch_reg_t;

    typedef logic [TAG_BITS-1:0] phys_tag_t;

    // One write word, two readings
    typedef union packed {
        // Dispatch of one decoded instruction
        struct packed {
            logic [16:0] spare;
            arch_reg_t   src2;
            arch_reg_t   src1;
            arch_reg_t   dst;
        } disp;
        // Completion report by ROB slot
        struct packed {
            logic [31-TAG_BITS:0] spare;
            phys_tag_t            rob_idx;
        } comp;
    } cmd_word_u;

endpackage

// ==== rename_unit.f ====
rename_cfg_pkg.sv
wb_map_pkg.sv
map_table.sv
free_list.sv
reorder_buffer.sv
wb_rename_regs.sv
rename_unit.sv
tb_rename_unit.sv

// ==== rename_unit.sv ====
`timescale 1ns/1ns
// Top of the register rename block
// A host on the Wishbone port dispatches, completes and flushes,
// and every in-order retirement shows on the commit ports
// PHYS_REGS and ROB_DEPTH are set here and passed down
module rename_unit
    import rename_cfg_pkg::*;
    import wb_map_pkg::*;
#(
    parameter int PHYS_REGS = 64,
    parameter int ROB_DEPTH = 16
) (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [ADDR_W-1:0] adr,
    input  logic [31:0]       dat_w,
    output logic              ack,
    output logic              err,
    output logic [31:0]       dat_r,
    output logic              commit_valid,
    output arch_reg_t         commit_arch,
    output phys_tag_t         commit_tag,
    output phys_tag_t         commit_old_tag
);
    localparam int IDX_W = $clog2(ROB_DEPTH);

    //////////////////////////////////////////////////
    // Wires
    //////////////////////////////////////////////////

    // Bus slave to the structures
    logic             dispatch;
    logic             complete;
    logic             flush;
    arch_reg_t        dst;
    arch_reg_t        src1;
    arch_reg_t        src2;
    logic [IDX_W-1:0] complete_idx;

    // Rename results
    phys_tag_t new_tag;
    phys_tag_t old_tag;
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;

    // Occupancy and checks back to the slave
    logic                rob_full;
    logic                fl_empty;
    logic [TAG_BITS:0]   rob_count;
    logic [TAG_BITS-1:0] fl_count;
    logic [IDX_W-1:0]    rob_tail;
    logic                complete_ok;

    //////////////////////////////////////////////////
    // Instances
    //////////////////////////////////////////////////

    wb_rename_regs #(
        .ROB_DEPTH (ROB_DEPTH)
    ) i_wb_rename_regs (
        .clock        (clock),
        .arst_n       (arst_n),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .dat_w        (dat_w),
        .ack          (ack),
        .err          (err),
        .dat_r        (dat_r),
        .rob_full     (rob_full),
        .fl_empty     (fl_empty),
        .rob_count    (rob_count),
        .fl_count     (fl_count),
        .rob_tail     (rob_tail),
        .new_tag      (new_tag),
        .old_tag      (old_tag),
        .src1_tag     (src1_tag),
        .src2_tag     (src2_tag),
        .complete_ok  (complete_ok),
        .dispatch     (dispatch),
        .complete     (complete),
        .flush        (flush),
        .dst          (dst),
        .src1         (src1),
        .src2         (src2),
        .complete_idx (complete_idx)
    );

    // Retirement drives the commit ports directly
    map_table #(
        .PHYS_REGS (PHYS_REGS)
    ) i_map_table (
        .clock       (clock),
        .arst_n      (arst_n),
        .dispatch    (dispatch),
        .flush       (flush),
        .dst         (dst),
        .src1        (src1),
        .src2        (src2),
        .new_tag     (new_tag),
        .retire      (commit_valid),
        .retire_arch (commit_arch),
        .retire_tag  (commit_tag),
        .old_tag     (old_tag),
        .src1_tag    (src1_tag),
        .src2_tag    (src2_tag)
    );

    free_list #(
        .PHYS_REGS (PHYS_REGS)
    ) i_free_list (
        .clock          (clock),
        .arst_n         (arst_n),
        .dispatch       (dispatch),
        .flush          (flush),
        .retire         (commit_valid),
        .retire_old_tag (commit_old_tag),
        .rob_count      (rob_count),
        .new_tag        (new_tag),
        .empty          (fl_empty),
        .count          (fl_count)
    );

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) i_reorder_buffer (
        .clock          (clock),
        .arst_n         (arst_n),
        .dispatch       (dispatch),
        .dst            (dst),
        .new_tag        (new_tag),
        .old_tag        (old_tag),
        .complete       (complete),
        .complete_idx   (complete_idx),
        .flush          (flush),
        .tail           (rob_tail),
        .full           (rob_full),
        .count          (rob_count),
        .complete_ok    (complete_ok),
        .retire         (commit_valid),
        .retire_arch    (commit_arch),
        .retire_tag     (commit_tag),
        .retire_old_tag (commit_old_tag)
    );

endmodule

// ==== reorder_buffer.sv ====
`timescale 1ns/1ns
// Reorder buffer for the rename block
// Entries are allocated at the tail on dispatch and marked done by
// the host's completion reports. The head retires once done, one
// entry per cycle, which frees its old tag and updates the
// retirement map. Flush drops every entry without a commit
module reorder_buffer
    import rename_cfg_pkg::*;
#(
    parameter  int ROB_DEPTH = 16,
    localparam int IDX_W     = $clog2(ROB_DEPTH)
) (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              dispatch,
    input  arch_reg_t         dst,
    input  phys_tag_t         new_tag,
    input  phys_tag_t         old_tag,
    input  logic              complete,
    input  logic [IDX_W-1:0]  complete_idx,
    input  logic              flush,
    output logic [IDX_W-1:0]  tail,
    output logic              full,
    output logic [TAG_BITS:0] count,
    output logic              complete_ok,
    output logic              retire,
    output arch_reg_t         retire_arch,
    output phys_tag_t         retire_tag,
    output phys_tag_t         retire_old_tag
);
    // Entry payload
    arch_reg_t ent_dst [ROB_DEPTH];
    phys_tag_t ent_new [ROB_DEPTH];
    phys_tag_t ent_old [ROB_DEPTH];

    // Entry state
    logic [ROB_DEPTH-1:0] ent_valid;
    logic [ROB_DEPTH-1:0] ent_done;
    logic [IDX_W-1:0]     head;

    function automatic logic [IDX_W-1:0] bump(input logic [IDX_W-1:0] ptr);
        return (ptr == IDX_W'(ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == (TAG_BITS + 1)'(ROB_DEPTH));

    // Only an occupied entry still waiting may be completed
    assign complete_ok = ent_valid[complete_idx] && !ent_done[complete_idx];

    // Head leaves when done, a flush discards it instead
    assign retire         = ent_valid[head] && ent_done[head] && !flush;
    assign retire_arch    = ent_dst[head];
    assign retire_tag     = ent_new[head];
    assign retire_old_tag = ent_old[head];

    //////////////////////////////////////////////////
    // Pointers and entry state
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ent_valid <= '0;
            ent_done  <= '0;
        end else if (flush) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ent_valid <= '0;
            ent_done  <= '0;
        end else begin
            if (dispatch) begin
                ent_valid[tail] <= 1'b1;
                ent_done[tail]  <= 1'b0;
                tail            <= bump(tail);
            end
            if (complete) begin
                ent_done[complete_idx] <= 1'b1;
            end
            if (retire) begin
                ent_valid[head] <= 1'b0;
                head            <= bump(head);
            end
            count <= count + (TAG_BITS + 1)'(dispatch) - (TAG_BITS + 1)'(retire);
        end
    end

    // Payload written at allocation
    always_ff @(posedge clock) begin
        if (dispatch) begin
            ent_dst[tail] <= dst;
            ent_new[tail] <= new_tag;
            ent_old[tail] <= old_tag;
        end
    end

endmodule

// ==== tb_rename_unit.sv ====
`timescale 1ns/1ns
// Self-checking testbench for the rename block
// Runs the operations of rename_cases.txt, a full-ROB test and a random
// dispatch and completion sequence against a model of maps, free list and ROB
// Commits are checked in order by a monitor
module tb_rename_unit;

    localparam int PHYS_REGS = 64;
    localparam int ROB_DEPTH = 16;

    logic        clock;
    logic        arst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [2:0]  adr;
    logic [31:0] dat_w;
    logic        ack;
    logic        err;
    logic [31:0] dat_r;
    logic        commit_valid;
    logic [4:0]  commit_arch;
    logic [7:0]  commit_tag;
    logic [7:0]  commit_old_tag;

    //////////////////////////////////////////////////
    // Model state
    //////////////////////////////////////////////////

    int          spec_map [32];
    int          arch_map [32];
    int          free_q [$];
    int          rob_dst [$];
    int          rob_new [$];
    int          rob_old [$];
    int          rob_idx [$];
    bit          rob_done [$];
    int          rob_tail;
    logic [31:0] exp_rename;
    logic [31:0] exp_src2;
    logic [31:0] case_mem [0:255];
    string       test_name;
    int          error_count;
    int          commit_count;
    int          tests_run;
    int          tests_failed;

    rename_unit #(
        .PHYS_REGS (PHYS_REGS),
        .ROB_DEPTH (ROB_DEPTH)
    ) i_rename_unit (
        .clock          (clock),
        .arst_n         (arst_n),
        .cyc            (cyc),
        .stb            (stb),
        .we             (we),
        .adr            (adr),
        .dat_w          (dat_w),
        .ack            (ack),
        .err            (err),
        .dat_r          (dat_r),
        .commit_valid   (commit_valid),
        .commit_arch    (commit_arch),
        .commit_tag     (commit_tag),
        .commit_old_tag (commit_old_tag)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Position of an occupied, not yet completed entry, or -1
    function automatic int find_busy(input int idx);
        for (int i = 0; i < rob_idx.size(); i++) begin
            if (rob_idx[i] == idx && !rob_done[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic logic [31:0] status_word();
        return {16'h0, 8'(free_q.size()), 8'(rob_dst.size())};
    endfunction

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("Mismatch %s %s expected %h actual %h", test_name, what, exp, act);
        error_count++;
    endtask

    //////////////////////////////////////////////////
    // Commit monitor
    //////////////////////////////////////////////////

    always @(posedge clock) begin
        if (arst_n && commit_valid) begin
            commit_count++;
            if (rob_dst.size() == 0) begin
                $display("Error %s: commit while the model ROB is empty", test_name);
                error_count++;
            end else begin
                if (!rob_done[0]) begin
                    $display("Error %s: commit of an entry never completed", test_name);
                    error_count++;
                end
                if (int'(commit_arch) != rob_dst[0]) mismatch("commit_arch", rob_dst[0], commit_arch);
                if (int'(commit_tag) != rob_new[0]) mismatch("commit_tag", rob_new[0], commit_tag);
                if (int'(commit_old_tag) != rob_old[0]) begin
                    mismatch("commit_old_tag", rob_old[0], commit_old_tag);
                end
                arch_map[rob_dst[0]] = rob_new[0];
                free_q.push_back(rob_old[0]);
                void'(rob_dst.pop_front());
                void'(rob_new.pop_front());
                void'(rob_old.pop_front());
                void'(rob_idx.pop_front());
                void'(rob_done.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////
    // Bus access
    //////////////////////////////////////////////////

    // Lets a completed head retire before the next access
    task automatic wait_retire_idle();
        int waited;
        waited = 0;
        @(negedge clock);
        while (rob_dst.size() > 0 && rob_done[0]) begin
            if (waited >= 50) abort("Timeout waiting for the ROB head to retire");
            @(negedge clock);
            waited++;
        end
    endtask

    task automatic bus_cycle(input logic wr, input logic [2:0] a, input logic [31:0] d,
                             output logic [31:0] rd, output logic got_err);
        int waited;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = a;
        dat_w = d;
        @(negedge clock);
        waited = 1;
        while (!ack && !err) begin
            if (waited >= 20) abort("Timeout waiting for ack or err on the bus");
            @(negedge clock);
            waited++;
        end
        rd      = dat_r;
        got_err = err;
        cyc     = 1'b0;
        stb     = 1'b0;
        we      = 1'b0;
    endtask

    // Write with legality and model update
    task automatic apply_write(input logic [2:0] a, input logic [31:0] d, output logic got_err);
        logic [31:0] rd;
        bit          legal;
        int          n;
        int          s1;
        int          s2;
        int          pos;
        // Legality is judged on the ROB after pending retirement
        wait_retire_idle();
        case (a)
            3'd0: legal = rob_dst.size() < ROB_DEPTH && free_q.size() > 0;
            3'd1: legal = find_busy(int'(d[7:0])) >= 0;
            3'd2: legal = 1'b1;
            default: legal = 1'b0;
        endcase
        bus_cycle(1'b1, a, d, rd, got_err);
        if (got_err != !legal) mismatch("err", 32'(!legal), 32'(got_err));
        if (legal && !got_err) begin
            if (a == 3'd0) begin
                n  = free_q.pop_front();
                s1 = spec_map[d[9:5]];
                s2 = spec_map[d[14:10]];
                exp_rename = {8'(s1), 8'(rob_tail), 8'(spec_map[d[4:0]]), 8'(n)};
                exp_src2   = 32'(s2);
                rob_dst.push_back(int'(d[4:0]));
                rob_new.push_back(n);
                rob_old.push_back(spec_map[d[4:0]]);
                rob_idx.push_back(rob_tail);
                rob_done.push_back(1'b0);
                spec_map[d[4:0]] = n;
                rob_tail = (rob_tail + 1) % ROB_DEPTH;
            end else if (a == 3'd1) begin
                pos = find_busy(int'(d[7:0]));
                rob_done[pos] = 1'b1;
            end else begin
                // In-flight tags go back to the front in program order
                for (int i = rob_new.size() - 1; i >= 0; i--) free_q.push_front(rob_new[i]);
                rob_dst.delete();
                rob_new.delete();
                rob_old.delete();
                rob_idx.delete();
                rob_done.delete();
                rob_tail = 0;
                for (int i = 0; i < 32; i++) spec_map[i] = arch_map[i];
            end
        end
    endtask

    task automatic apply_read(input logic [2:0] a, output logic [31:0] rd, output logic got_err);
        bit legal;
        wait_retire_idle();
        legal = (a >= 3'd3 && a <= 3'd5);
        bus_cycle(1'b0, a, 32'h0, rd, got_err);
        if (got_err != !legal) mismatch("err", 32'(!legal), 32'(got_err));
    endtask

    task automatic report_test(input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, error_count - errs_before);
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] rd;
        logic [31:0] rnd;
        logic        got_err;
        int          errs;
        int          commits;
        int          pos;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        arst_n = 1'b0;
        error_count = 0;
        commit_count = 0;
        tests_run = 0;
        tests_failed = 0;
        rob_tail = 0;
        test_name = "reset";
        for (int i = 0; i < 32; i++) begin
            spec_map[i] = i;
            arch_map[i] = i;
        end
        for (int i = 32; i < PHYS_REGS; i++) free_q.push_back(i);
        $readmemh("rename_cases.txt", case_mem);
        repeat (10) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        // Directed operations from the data file
        test_name = "cases";
        errs = error_count;
        for (int i = 0; case_mem[i * 4] !== 32'hff; i++) begin
            if (i >= 63) abort("Case list has no end marker");
            if (case_mem[i * 4] == 32'h0) begin
                apply_write(case_mem[i * 4 + 1][2:0], case_mem[i * 4 + 2], got_err);
            end else begin
                apply_read(case_mem[i * 4 + 1][2:0], rd, got_err);
                if (!case_mem[i * 4 + 3][0] && rd !== case_mem[i * 4 + 2]) begin
                    mismatch($sformatf("case %0d read", i), case_mem[i * 4 + 2], rd);
                end
            end
            if (got_err !== case_mem[i * 4 + 3][0]) begin
                mismatch($sformatf("case %0d err", i), case_mem[i * 4 + 3], 32'(got_err));
            end
        end
        report_test(errs);

        // Fill the ROB, refuse one more, then retire all in reverse completion
        test_name = "rob_full";
        errs = error_count;
        commits = commit_count;
        for (int i = 0; i < ROB_DEPTH; i++) apply_write(3'd0, 32'(i % 32), got_err);
        apply_write(3'd0, 32'h7, got_err);
        if (!got_err) mismatch("dispatch into full ROB err", 32'h1, 32'h0);
        apply_read(3'd5, rd, got_err);
        if (rd !== status_word()) mismatch("status", status_word(), rd);
        for (int i = ROB_DEPTH - 1; i >= 0; i--) apply_write(3'd1, 32'(rob_idx[i]), got_err);
        wait_retire_idle();
        if (commit_count - commits != ROB_DEPTH) begin
            mismatch("commit count", 32'(ROB_DEPTH), 32'(commit_count - commits));
        end
        report_test(errs);

        // Random dispatches and completions against the model
        test_name = "random";
        errs = error_count;
        rnd = 32'd33;
        for (int i = 0; i < 300; i++) begin
            rnd = xorshift(rnd);
            if (rnd[1:0] != 2'd0 || rob_dst.size() == 0) begin
                apply_write(3'd0, {17'h0, rnd[26:12]}, got_err);
            end else begin
                pos = int'(rnd[11:4]) % rob_dst.size();
                apply_write(3'd1, 32'(rob_idx[pos]), got_err);
            end
            if (i % 8 == 7) begin
                apply_read(3'd3, rd, got_err);
                if (rd !== exp_rename) mismatch("last rename", exp_rename, rd);
                apply_read(3'd4, rd, got_err);
                if (rd !== exp_src2) mismatch("last src2", exp_src2, rd);
                apply_read(3'd5, rd, got_err);
                if (rd !== status_word()) mismatch("status", status_word(), rd);
            end
        end
        // Drain from the youngest entry so the head completes last
        wait_retire_idle();
        for (int i = rob_idx.size() - 1; i >= 0; i--) begin
            if (!rob_done[i]) apply_write(3'd1, 32'(rob_idx[i]), got_err);
        end
        wait_retire_idle();
        apply_read(3'd5, rd, got_err);
        if (rd !== status_word()) mismatch("final status", status_word(), rd);
        report_test(errs);

        $display("Tests %0d, failed %0d, errors %0d, commits %0d",
                 tests_run, tests_failed, error_count, commit_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== wb_map_pkg.sv ====
// Register map of the Wishbone slave port
// Word addresses first, then byte lanes of the read words
package wb_map_pkg;

    localparam int ADDR_W = 3;

    // Write only
    localparam logic [ADDR_W-1:0] ADDR_DISPATCH    = 3'd0;
    localparam logic [ADDR_W-1:0] ADDR_COMPLETE    = 3'd1;
    localparam logic [ADDR_W-1:0] ADDR_FLUSH       = 3'd2;

    // Read only
    localparam logic [ADDR_W-1:0] ADDR_LAST_RENAME = 3'd3;
    localparam logic [ADDR_W-1:0] ADDR_LAST_SRC2   = 3'd4;
    localparam logic [ADDR_W-1:0] ADDR_STATUS      = 3'd5;

    // Last rename word, one byte per field
    localparam int RN_NEW_LSB  = 0;
    localparam int RN_OLD_LSB  = 8;
    localparam int RN_ROB_LSB  = 16;
    localparam int RN_SRC1_LSB = 24;
    localparam int RN_SRC2_LSB = 0;

    // Status word
    localparam int ST_ROB_LSB = 0;
    localparam int ST_FL_LSB  = 8;

endpackage

// ==== wb_rename_regs.sv ====
`timescale 1ns/1ns
// Wishbone classic slave in front of the rename structures
// Every access ends one cycle after the request with ack or err,
// a refused command ends with err and changes nothing
// Accepted writes leave as one-cycle dispatch, complete or flush pulses
// Reads return the last rename result or the occupancy status
module wb_rename_regs
    import rename_cfg_pkg::*;
    import wb_map_pkg::*;
#(
    parameter  int ROB_DEPTH = 16,
    localparam int IDX_W     = $clog2(ROB_DEPTH)
) (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  logic [ADDR_W-1:0]   adr,
    input  logic [31:0]         dat_w,
    output logic                ack,
    output logic                err,
    output logic [31:0]         dat_r,
    input  logic                rob_full,
    input  logic                fl_empty,
    input  logic [TAG_BITS:0]   rob_count,
    input  logic [TAG_BITS-1:0] fl_count,
    input  logic [IDX_W-1:0]    rob_tail,
    input  phys_tag_t           new_tag,
    input  phys_tag_t           old_tag,
    input  phys_tag_t           src1_tag,
    input  phys_tag_t           src2_tag,
    input  logic                complete_ok,
    output logic                dispatch,
    output logic                complete,
    output logic                flush,
    output arch_reg_t           dst,
    output arch_reg_t           src1,
    output arch_reg_t           src2,
    output logic [IDX_W-1:0]    complete_idx
);
    cmd_word_u cmd;
    logic      req;
    logic      idx_in_range;
    logic      legal;
    logic      accept;

    // Captured result of the last accepted dispatch
    phys_tag_t last_new;
    phys_tag_t last_old;
    phys_tag_t last_rob;
    phys_tag_t last_src1;
    phys_tag_t last_src2;

    assign cmd = dat_w;

    // First cycle of a request only, the ack cycle is not a new one
    assign req = cyc && stb && !ack && !err;

    //////////////////////////////////////////////////
    // Access decode
    //////////////////////////////////////////////////

    assign idx_in_range = int'(cmd.comp.rob_idx) < ROB_DEPTH;

    always_comb begin
        case (adr)
            ADDR_DISPATCH: legal = we && !rob_full && !fl_empty;
            ADDR_COMPLETE: legal = we && idx_in_range && complete_ok;
            ADDR_FLUSH:    legal = we;
            ADDR_LAST_RENAME, ADDR_LAST_SRC2, ADDR_STATUS: begin
                legal = !we;
            end
            // Unmapped words
            default:       legal = 1'b0;
        endcase
    end

    assign accept = req && legal;

    // Pulses share the cycle in which ack is registered
    assign dispatch = accept && (adr == ADDR_DISPATCH);
    assign complete = accept && (adr == ADDR_COMPLETE);
    assign flush    = accept && (adr == ADDR_FLUSH);

    assign dst          = cmd.disp.dst;
    assign src1         = cmd.disp.src1;
    assign src2         = cmd.disp.src2;
    assign complete_idx = cmd.comp.rob_idx[IDX_W-1:0];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ack <= 1'b0;
            err <= 1'b0;
        end else begin
            ack <= accept;
            err <= req && !legal;
        end
    end

    //////////////////////////////////////////////////
    // Readback
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (dispatch) begin
            last_new  <= new_tag;
            last_old  <= old_tag;
            last_rob  <= phys_tag_t'(rob_tail);
            last_src1 <= src1_tag;
            last_src2 <= src2_tag;
        end
    end

    always_comb begin
        dat_r = '0;
        case (adr)
            ADDR_LAST_RENAME: begin
                dat_r[RN_NEW_LSB +: TAG_BITS]  = last_new;
                dat_r[RN_OLD_LSB +: TAG_BITS]  = last_old;
                dat_r[RN_ROB_LSB +: TAG_BITS]  = last_rob;
                dat_r[RN_SRC1_LSB +: TAG_BITS] = last_src1;
            end
            ADDR_LAST_SRC2: dat_r[RN_SRC2_LSB +: TAG_BITS] = last_src2;
            ADDR_STATUS: begin
                // Full ROB of 256 wraps to 0 in its byte
                dat_r[ST_ROB_LSB +: TAG_BITS] = rob_count[TAG_BITS-1:0];
                dat_r[ST_FL_LSB +: TAG_BITS]  = fl_count;
            end
            default: dat_r = '0;
        endcase
    end

endmodule
